// ==== Bender.yml ====
package:
  name: rv64_pipe_core

export_include_dirs:
  - verilog

sources:
  - verilog/isaPkg.sv
  - verilog/pipePkg.sv
  - verilog/InstDecoder.sv
  - verilog/RegFile.sv
  - verilog/HazardUnit.sv
  - verilog/ExecuteUnit.sv
  - verilog/Core.sv
  - target: test
    files:
      - tb/CoreTb.sv

// ==== src.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/InstDecoder.sv
verilog/RegFile.sv
verilog/HazardUnit.sv
verilog/ExecuteUnit.sv
verilog/Core.sv
tb/CoreTb.sv

// ==== tb/CoreTb.sv ====
`include "core_cfg.svh"

module CoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ProgLen = 200;
    localparam int ImemDepth = 256;
    localparam int DmemWords = 32;
    localparam int CommitTimeout = 50;

    logic               clk;
    logic               rst;
    isaPkg::word        instAddr;
    isaPkg::instWord    inst;
    isaPkg::word        dataAddr;
    isaPkg::word        dataWdata;
    isaPkg::word        dataRdata;
    logic               dataWe;
    logic               dataRe;
    logic               commitValid;
    pipePkg::commitInfo commit;

    integer             seed;
    isaPkg::instWord    prog [ImemDepth];
    isaPkg::word        dmem [DmemWords];
    isaPkg::word        modelRegs [`CORE_REG_COUNT];
    isaPkg::word        modelMem [DmemWords];
    pipePkg::commitInfo expCommits [$];
    isaPkg::word        expStAddr [$];
    isaPkg::word        expStData [$];
    isaPkg::word        expLdAddr [$];

    Core DUT (
        .clk         (clk),
        .rst         (rst),
        .instAddr    (instAddr),
        .inst        (inst),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .dataWe      (dataWe),
        .dataRe      (dataRe),
        .dataRdata   (dataRdata),
        .commitValid (commitValid),
        .commit      (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // both memories answer in the same cycle
    assign inst      = prog[instAddr[9:2]];
    assign dataRdata = dmem[dataAddr[7:3]];

    always @(posedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[7:3]] <= dataWdata;
        end
    end

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic isaPkg::word fillValue(int idx);
        return isaPkg::word'(idx * 8) * 64'h9e37_79b9_7f4a_7c15 ^ 64'h0123_4567_89ab_cdef;
    endfunction

    function automatic isaPkg::instWord rType(logic [6:0] f7, logic [2:0] f3,
                                              isaPkg::regIdx rd, isaPkg::regIdx rs1,
                                              isaPkg::regIdx rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic isaPkg::instWord iType(logic [6:0] op, logic [2:0] f3, isaPkg::regIdx rd,
                                              isaPkg::regIdx rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic isaPkg::instWord sType(isaPkg::regIdx rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic isaPkg::instWord bType(logic [2:0] f3, isaPkg::regIdx rs1,
                                              isaPkg::regIdx rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic isaPkg::instWord jType(isaPkg::regIdx rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic genProgram();
        int            i;
        int unsigned   k;
        isaPkg::regIdx rd;
        isaPkg::regIdx rs1;
        isaPkg::regIdx rs2;
        i = 0;
        while (i < ProgLen) begin
            k   = pick(20);
            rd  = isaPkg::regIdx'(pick(8));
            rs1 = isaPkg::regIdx'(pick(8));
            rs2 = isaPkg::regIdx'(pick(8));
            if (k < 6 || k == 19) begin
                // k == 19 aims at x0
                if (k == 19) rd = '0;
                case (pick(9))
                    0: prog[i] = rType(7'h00, 3'd0, rd, rs1, rs2);
                    1: prog[i] = rType(7'h20, 3'd0, rd, rs1, rs2);
                    2: prog[i] = rType(7'h00, 3'd7, rd, rs1, rs2);
                    3: prog[i] = rType(7'h00, 3'd6, rd, rs1, rs2);
                    4: prog[i] = rType(7'h00, 3'd4, rd, rs1, rs2);
                    5: prog[i] = rType(7'h00, 3'd2, rd, rs1, rs2);
                    6: prog[i] = rType(7'h00, 3'd1, rd, rs1, rs2);
                    7: prog[i] = rType(7'h00, 3'd5, rd, rs1, rs2);
                    default: prog[i] = rType(7'h20, 3'd5, rd, rs1, rs2);
                endcase
            end else if (k < 10) begin
                case (pick(5))
                    0: prog[i] = iType(7'h13, 3'd0, rd, rs1, 12'(pick(4096)));
                    1: prog[i] = iType(7'h13, 3'd2, rd, rs1, 12'(pick(4096)));
                    2: prog[i] = iType(7'h13, 3'd4, rd, rs1, 12'(pick(4096)));
                    3: prog[i] = iType(7'h13, 3'd6, rd, rs1, 12'(pick(4096)));
                    default: prog[i] = iType(7'h13, 3'd7, rd, rs1, 12'(pick(4096)));
                endcase
            end else if (k == 10) begin
                prog[i] = {20'(pick(1 << 20)), rd, 7'b0110111};
            end else if (k < 13) begin
                prog[i] = iType(7'h03, 3'd3, rd, 5'd0, 12'(pick(DmemWords) * 8));
                // dependent use right behind the load
                if (i + 1 < ProgLen) begin
                    i++;
                    prog[i] = rType(7'h00, 3'd0, isaPkg::regIdx'(pick(8)), rd, rs2);
                end
            end else if (k < 15) begin
                prog[i] = sType(rs2, 12'(pick(DmemWords) * 8));
            end else if (k < 18) begin
                case (pick(4))
                    0: prog[i] = bType(3'd0, rs1, rs2, 13'((1 + pick(6)) * 4));
                    1: prog[i] = bType(3'd1, rs1, rs2, 13'((1 + pick(6)) * 4));
                    2: prog[i] = bType(3'd4, rs1, rs2, 13'((1 + pick(6)) * 4));
                    default: prog[i] = bType(3'd5, rs1, rs2, 13'((1 + pick(6)) * 4));
                endcase
            end else begin
                prog[i] = jType(rd, 21'((1 + pick(6)) * 4));
            end
            i++;
        end
    endtask

    // instruction-level model, follows the taken path only
    task automatic runModel();
        isaPkg::word        pc;
        isaPkg::word        a;
        isaPkg::word        b;
        isaPkg::word        immI;
        isaPkg::word        addr;
        isaPkg::word        val;
        isaPkg::word        nextPc;
        isaPkg::instWord    ins;
        logic [2:0]         f3;
        logic               writes;
        pipePkg::commitInfo rec;
        pc = `CORE_RESET_PC;
        while (pc < ProgLen * 4) begin
            ins    = prog[pc[9:2]];
            f3     = ins[14:12];
            a      = modelRegs[ins[19:15]];
            b      = modelRegs[ins[24:20]];
            immI   = {{52{ins[31]}}, ins[31:20]};
            nextPc = pc + 4;
            writes = 1'b1;
            val    = '0;
            case (ins[6:0])
                7'b0110011: begin
                    case (f3)
                        3'd0: val = ins[30] ? a - b : a + b;
                        3'd1: val = a << b[5:0];
                        3'd2: val = isaPkg::word'($signed(a) < $signed(b));
                        3'd4: val = a ^ b;
                        3'd5: val = ins[30] ? $signed(a) >>> b[5:0] : a >> b[5:0];
                        3'd6: val = a | b;
                        default: val = a & b;
                    endcase
                end
                7'b0010011: begin
                    case (f3)
                        3'd0: val = a + immI;
                        3'd2: val = isaPkg::word'($signed(a) < $signed(immI));
                        3'd4: val = a ^ immI;
                        3'd6: val = a | immI;
                        default: val = a & immI;
                    endcase
                end
                7'b0110111: val = {{32{ins[31]}}, ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + immI;
                    val  = modelMem[addr[7:3]];
                    expLdAddr.push_back(addr);
                end
                7'b0100011: begin
                    writes = 1'b0;
                    addr   = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    modelMem[addr[7:3]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                end
                7'b1100011: begin
                    writes = 1'b0;
                    if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b) ||
                        (f3 == 3'd4 && $signed(a) < $signed(b)) ||
                        (f3 == 3'd5 && $signed(a) >= $signed(b))) begin
                        nextPc = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25],
                                       ins[11:8], 1'b0};
                    end
                end
                default: begin
                    val    = pc + 4;
                    nextPc = pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
            endcase
            rec.pc     = pc;
            rec.rd     = ins[11:7];
            rec.regWe  = writes && ins[11:7] != 5'd0;
            rec.rdData = val;
            if (rec.regWe) modelRegs[rec.rd] = val;
            expCommits.push_back(rec);
            pc = nextPc;
        end
    endtask

    task automatic reportMismatch(string name, logic [63:0] exp, logic [63:0] act);
        $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        $display("Test failures found");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic checkWord(string name, isaPkg::word exp, isaPkg::word act);
        if (act !== exp) reportMismatch(name, exp, act);
    endtask

    task automatic checkRegIdx(string name, isaPkg::regIdx exp, isaPkg::regIdx act);
        if (act !== exp) reportMismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp) reportMismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic watchStores();
        if (dataWe === 1'b1) begin
            if (expStAddr.size() == 0) begin
                $display("Store at %0t ns was not expected by the model", $time);
                $display("Test failures found");
                $fatal(1, "unexpected store");
            end else begin
                checkWord("dataAddr", expStAddr.pop_front(), dataAddr);
                checkWord("dataWdata", expStData.pop_front(), dataWdata);
            end
        end
    endtask

    task automatic watchLoads();
        if (dataRe === 1'b1) begin
            if (expLdAddr.size() == 0) begin
                $display("Load at %0t ns was not expected by the model", $time);
                $display("Test failures found");
                $fatal(1, "unexpected load");
            end else begin
                checkWord("dataAddr", expLdAddr.pop_front(), dataAddr);
            end
        end
    endtask

    task automatic awaitCommit();
        pipePkg::commitInfo exp;
        int                 waited;
        waited = 0;
        do begin
            @(negedge clk);
            watchStores();
            watchLoads();
            waited++;
        end while (commitValid !== 1'b1 && waited < CommitTimeout);
        if (commitValid !== 1'b1) begin
            $display("Timeout: no instruction retired within %0d cycles", CommitTimeout);
            $display("Test failures found");
            $fatal(1, "retirement timeout");
        end else begin
            exp = expCommits.pop_front();
            checkWord("commit.pc", exp.pc, commit.pc);
            checkBit("commit.regWe", exp.regWe, commit.regWe);
            checkRegIdx("commit.rd", exp.rd, commit.rd);
            if (exp.regWe) checkWord("commit.rdData", exp.rdData, commit.rdData);
        end
    endtask

    initial begin
        rst  = 1'b1;
        seed = 32'h26ea_2cbc;
        for (int i = 0; i < ImemDepth; i++) prog[i] = `CORE_NOP;
        for (int i = 0; i < DmemWords; i++) begin
            dmem[i]     = fillValue(i);
            modelMem[i] = fillValue(i);
        end
        for (int i = 0; i < `CORE_REG_COUNT; i++) modelRegs[i] = '0;
        genProgram();
        runModel();

        // last check lands on the first cycle out of reset
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            if (c == 15) rst <= 1'b0;
            @(negedge clk);
            checkBit("commitValid", 1'b0, commitValid);
            checkBit("dataWe", 1'b0, dataWe);
            checkBit("dataRe", 1'b0, dataRe);
            checkWord("instAddr", `CORE_RESET_PC, instAddr);
        end

        while (expCommits.size() > 0) awaitCommit();

        if (expStAddr.size() != 0 || expLdAddr.size() != 0) begin
            $display("%0d stores and %0d loads of the model were never issued",
                     expStAddr.size(), expLdAddr.size());
            $display("Test failures found");
            $fatal(1, "missing memory accesses");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== verilog/Core.sv ====
`include "core_cfg.svh"

module Core (
    input  logic               clk,
    input  logic               rst,

    output isaPkg::word        instAddr,
    input  isaPkg::instWord    inst,

    output isaPkg::word        dataAddr,
    output isaPkg::word        dataWdata,
    output logic               dataWe,
    output logic               dataRe,
    input  isaPkg::word        dataRdata,

    output logic               commitValid,
    output pipePkg::commitInfo commit
);
    isaPkg::word        pc;
    logic               ifIdValid;
    isaPkg::word        ifIdPc;
    isaPkg::instWord    ifIdInst;
    pipePkg::idExReg    idEx;
    pipePkg::exMemReg   exMem;
    pipePkg::memWbReg   memWb;

    pipePkg::ctrlBundle decCtrl;
    isaPkg::word        decImm;
    isaPkg::regIdx      decRs1;
    isaPkg::regIdx      decRs2;
    isaPkg::word        rs1Data;
    isaPkg::word        rs2Data;
    pipePkg::fwdSel     fwdA;
    pipePkg::fwdSel     fwdB;
    logic               stall;
    logic               flush;
    isaPkg::word        aluRes;
    isaPkg::word        storeData;
    isaPkg::word        redirectPc;
    logic               redirect;
    isaPkg::word        memData;

    // fetch
    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + 4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ifIdValid <= 1'b0;
            ifIdInst  <= `CORE_NOP;
        end else if (!stall) begin
            ifIdValid <= 1'b1;
            ifIdInst  <= inst;
        end
        if (!stall) begin
            ifIdPc <= pc;
        end
    end

    // decode
    assign decRs1 = ifIdInst[19:15];
    assign decRs2 = ifIdInst[24:20];

    InstDecoder decoder (
        .inst (ifIdInst),
        .ctrl (decCtrl),
        .imm  (decImm)
    );

    RegFile regFile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (decRs1),
        .rs2     (decRs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (memWb.valid && memWb.regWe),
        .rd      (memWb.rd),
        .rdData  (memWb.wbData)
    );

    HazardUnit hazard (
        .idEx     (idEx),
        .exMem    (exMem),
        .memWb    (memWb),
        .decRs1   (decRs1),
        .decRs2   (decRs2),
        .redirect (redirect),
        .fwdA     (fwdA),
        .fwdB     (fwdB),
        .stall    (stall),
        .flush    (flush)
    );

    // stall and flush both leave a bubble in execute
    always_ff @(posedge clk) begin
        if (rst) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid <= ifIdValid && !stall && !flush;
        end
        idEx.pc      <= ifIdPc;
        idEx.ctrl    <= decCtrl;
        idEx.rs1     <= decRs1;
        idEx.rs2     <= decRs2;
        idEx.rd      <= ifIdInst[11:7];
        idEx.rs1Data <= rs1Data;
        idEx.rs2Data <= rs2Data;
        idEx.imm     <= decImm;
    end

    // execute
    ExecuteUnit execute (
        .idEx       (idEx),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .memFwd     (exMem.aluRes),
        .wbFwd      (memWb.wbData),
        .aluRes     (aluRes),
        .storeData  (storeData),
        .redirectPc (redirectPc),
        .redirect   (redirect)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid <= idEx.valid;
        end
        exMem.pc        <= idEx.pc;
        exMem.ctrl      <= idEx.ctrl;
        exMem.rd        <= idEx.rd;
        exMem.aluRes    <= aluRes;
        exMem.storeData <= storeData;
    end

    // memory
    assign dataAddr  = exMem.aluRes;
    assign dataWdata = exMem.storeData;
    assign dataWe    = exMem.valid && exMem.ctrl.memWe;
    assign dataRe    = exMem.valid && exMem.ctrl.memRe;
    assign memData   = exMem.ctrl.memRe ? dataRdata : exMem.aluRes;

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb.valid <= 1'b0;
        end else begin
            memWb.valid <= exMem.valid;
        end
        memWb.pc     <= exMem.pc;
        memWb.regWe  <= exMem.ctrl.regWe;
        memWb.rd     <= exMem.rd;
        memWb.wbData <= memData;
    end

    // writeback doubles as the retirement record
    assign commitValid = memWb.valid;
    assign commit      = '{pc: memWb.pc, regWe: memWb.regWe, rd: memWb.rd, rdData: memWb.wbData};

endmodule

// ==== verilog/ExecuteUnit.sv ====
module ExecuteUnit (
    input  pipePkg::idExReg idEx,
    input  pipePkg::fwdSel  fwdA,
    input  pipePkg::fwdSel  fwdB,
    input  isaPkg::word     memFwd,
    input  isaPkg::word     wbFwd,
    output isaPkg::word     aluRes,
    output isaPkg::word     storeData,
    output isaPkg::word     redirectPc,
    output logic            redirect
);
    localparam int ShW = $clog2($bits(isaPkg::word));

    isaPkg::word    opA;
    isaPkg::word    srcB;
    isaPkg::word    opB;
    logic [ShW-1:0] shAmt;
    logic           aluLess;
    logic           taken;

    always_comb begin
        case (fwdA)
            pipePkg::fwdMem: opA = memFwd;
            pipePkg::fwdWb:  opA = wbFwd;
            default:         opA = idEx.rs1Data;
        endcase
    end

    always_comb begin
        case (fwdB)
            pipePkg::fwdMem: srcB = memFwd;
            pipePkg::fwdWb:  srcB = wbFwd;
            default:         srcB = idEx.rs2Data;
        endcase
    end

    assign opB       = idEx.ctrl.useImm ? idEx.imm : srcB;
    assign storeData = srcB;
    assign shAmt     = opB[ShW-1:0];
    assign aluLess   = $signed(opA) < $signed(opB);

    always_comb begin
        case (idEx.ctrl.alu)
            isaPkg::aluSub:   aluRes = opA - opB;
            isaPkg::aluAnd:   aluRes = opA & opB;
            isaPkg::aluOr:    aluRes = opA | opB;
            isaPkg::aluXor:   aluRes = opA ^ opB;
            isaPkg::aluSlt:   aluRes = isaPkg::word'(aluLess);
            isaPkg::aluSll:   aluRes = opA << shAmt;
            isaPkg::aluSrl:   aluRes = opA >> shAmt;
            isaPkg::aluSra:   aluRes = $signed(opA) >>> shAmt;
            isaPkg::aluPassB: aluRes = opB;
            default:          aluRes = opA + opB;
        endcase
        // link value
        if (idEx.ctrl.isJal) begin
            aluRes = idEx.pc + 4;
        end
    end

    // compare uses register operands, imm is the offset
    always_comb begin
        case (idEx.ctrl.brOp)
            isaPkg::brNe: taken = opA != srcB;
            isaPkg::brLt: taken = $signed(opA) < $signed(srcB);
            isaPkg::brGe: taken = $signed(opA) >= $signed(srcB);
            default:      taken = opA == srcB;
        endcase
    end

    assign redirect   = idEx.valid && ((idEx.ctrl.isBranch && taken) || idEx.ctrl.isJal);
    assign redirectPc = idEx.pc + idEx.imm;

endmodule

// ==== verilog/HazardUnit.sv ====
module HazardUnit (
    input  pipePkg::idExReg  idEx,
    input  pipePkg::exMemReg exMem,
    input  pipePkg::memWbReg memWb,
    input  isaPkg::regIdx    decRs1,
    input  isaPkg::regIdx    decRs2,
    input  logic             redirect,
    output pipePkg::fwdSel   fwdA,
    output pipePkg::fwdSel   fwdB,
    output logic             stall,
    output logic             flush
);
    logic loadUse;

    // younger producer wins
    function automatic pipePkg::fwdSel pickFwd(isaPkg::regIdx src, pipePkg::exMemReg mem,
                                               pipePkg::memWbReg wb);
        pipePkg::fwdSel sel;
        sel = pipePkg::fwdNone;
        if (src != '0) begin
            if (mem.valid && mem.ctrl.regWe && mem.rd == src) begin
                sel = pipePkg::fwdMem;
            end else if (wb.valid && wb.regWe && wb.rd == src) begin
                sel = pipePkg::fwdWb;
            end
        end
        return sel;
    endfunction

    assign fwdA = pickFwd(idEx.rs1, exMem, memWb);
    assign fwdB = pickFwd(idEx.rs2, exMem, memWb);

    // load data is only ready from writeback
    assign loadUse = idEx.valid && idEx.ctrl.memRe && idEx.ctrl.regWe &&
                     (idEx.rd == decRs1 || idEx.rd == decRs2);

    assign flush = redirect;
    assign stall = loadUse && !redirect;

endmodule

// ==== verilog/InstDecoder.sv ====
module InstDecoder (
    input  isaPkg::instWord    inst,
    output pipePkg::ctrlBundle ctrl,
    output isaPkg::word        imm
);
    isaPkg::regIdx rd;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          regLegal;
    logic          writesRd;

    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // sub and sra are the only funct7 variants handled
    assign regLegal = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 &&
                       (funct3 == isaPkg::f3AddSub || funct3 == isaPkg::f3Shr));

    always_comb begin
        ctrl.memWe    = 1'b0;
        ctrl.memRe    = 1'b0;
        ctrl.isBranch = 1'b0;
        ctrl.isJal    = 1'b0;
        ctrl.useImm   = 1'b0;
        ctrl.brOp     = isaPkg::brEq;
        ctrl.alu      = isaPkg::aluAdd;
        writesRd      = 1'b0;
        imm           = '0;
        case (inst[6:0])
            isaPkg::opReg: begin
                writesRd = regLegal && funct3 != 3'b011;
                case (funct3)
                    isaPkg::f3AddSub: ctrl.alu = funct7[5] ? isaPkg::aluSub : isaPkg::aluAdd;
                    isaPkg::f3Sll:    ctrl.alu = isaPkg::aluSll;
                    isaPkg::f3Slt:    ctrl.alu = isaPkg::aluSlt;
                    isaPkg::f3Xor:    ctrl.alu = isaPkg::aluXor;
                    isaPkg::f3Shr:    ctrl.alu = funct7[5] ? isaPkg::aluSra : isaPkg::aluSrl;
                    isaPkg::f3Or:     ctrl.alu = isaPkg::aluOr;
                    isaPkg::f3And:    ctrl.alu = isaPkg::aluAnd;
                    default:          ctrl.alu = isaPkg::aluAdd;
                endcase
            end
            isaPkg::opImm: begin
                ctrl.useImm = 1'b1;
                imm         = isaPkg::word'($signed(inst[31:20]));
                // immediate shifts and sltiu fall through as no-ops
                writesRd    = 1'b1;
                case (funct3)
                    isaPkg::f3AddSub: ctrl.alu = isaPkg::aluAdd;
                    isaPkg::f3Slt:    ctrl.alu = isaPkg::aluSlt;
                    isaPkg::f3Xor:    ctrl.alu = isaPkg::aluXor;
                    isaPkg::f3Or:     ctrl.alu = isaPkg::aluOr;
                    isaPkg::f3And:    ctrl.alu = isaPkg::aluAnd;
                    default:          writesRd = 1'b0;
                endcase
            end
            isaPkg::opLui: begin
                ctrl.useImm = 1'b1;
                ctrl.alu    = isaPkg::aluPassB;
                imm         = isaPkg::word'($signed({inst[31:12], 12'b0}));
                writesRd    = 1'b1;
            end
            isaPkg::opLoad: begin
                ctrl.memRe  = 1'b1;
                ctrl.useImm = 1'b1;
                imm         = isaPkg::word'($signed(inst[31:20]));
                writesRd    = 1'b1;
            end
            isaPkg::opStore: begin
                ctrl.memWe  = 1'b1;
                ctrl.useImm = 1'b1;
                imm         = isaPkg::word'($signed({inst[31:25], inst[11:7]}));
            end
            isaPkg::opBranch: begin
                imm = isaPkg::word'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
                ctrl.isBranch = 1'b1;
                case (funct3)
                    isaPkg::f3Beq: ctrl.brOp = isaPkg::brEq;
                    isaPkg::f3Bne: ctrl.brOp = isaPkg::brNe;
                    isaPkg::f3Blt: ctrl.brOp = isaPkg::brLt;
                    isaPkg::f3Bge: ctrl.brOp = isaPkg::brGe;
                    default:       ctrl.isBranch = 1'b0;
                endcase
            end
            isaPkg::opJal: begin
                ctrl.isJal = 1'b1;
                imm = isaPkg::word'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
                writesRd   = 1'b1;
            end
            default: begin
                writesRd = 1'b0;
            end
        endcase
        // x0 destinations never write
        ctrl.regWe = writesRd && rd != '0;
    end

endmodule

// ==== verilog/RegFile.sv ====
`include "core_cfg.svh"

module RegFile (
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::regIdx rs1,
    input  isaPkg::regIdx rs2,
    output isaPkg::word   rs1Data,
    output isaPkg::word   rs2Data,
    input  logic          we,
    input  isaPkg::regIdx rd,
    input  isaPkg::word   rdData
);
    // x0 has no storage
    isaPkg::word regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rdData;
        end
    end

    // same-cycle writeback is visible to decode
    assign rs1Data = (rs1 == '0) ? '0 : (we && rd == rs1) ? rdData : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : (we && rd == rs2) ? rdData : regs[rs2];

endmodule

// ==== verilog/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// integer register and datapath width
`define CORE_XLEN 64

// architectural integer registers, x0 included
`define CORE_REG_COUNT 32

// first fetch address out of reset
`define CORE_RESET_PC 64'h0000_0000_0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

// ==== verilog/isaPkg.sv ====
`include "core_cfg.svh"

package isaPkg;

    typedef logic [`CORE_XLEN-1:0] word;
    typedef logic [31:0] instWord;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] regIdx;

    // only the major opcodes this core executes
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcode;

    // funct3 of register and immediate arithmetic
    typedef enum logic [2:0] {
        f3AddSub = 3'b000,
        f3Sll    = 3'b001,
        f3Slt    = 3'b010,
        f3Xor    = 3'b100,
        f3Shr    = 3'b101,
        f3Or     = 3'b110,
        f3And    = 3'b111
    } aluFunct3;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        f3Beq = 3'b000,
        f3Bne = 3'b001,
        f3Blt = 3'b100,
        f3Bge = 3'b101
    } brFunct3;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB
    } aluOp;

    typedef enum logic [1:0] {
        brEq,
        brNe,
        brLt,
        brGe
    } branchOp;

endpackage

// ==== verilog/pipePkg.sv ====
package pipePkg;

    // decoded control, carried down the pipe with each instruction
    typedef struct packed {
        logic            regWe;
        logic            memWe;
        logic            memRe;
        logic            isBranch;
        logic            isJal;
        logic            useImm;
        isaPkg::branchOp brOp;
        isaPkg::aluOp    alu;
    } ctrlBundle;

    // operand source in execute
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSel;

    typedef struct packed {
        logic          valid;
        isaPkg::word   pc;
        ctrlBundle     ctrl;
        isaPkg::regIdx rs1;
        isaPkg::regIdx rs2;
        isaPkg::regIdx rd;
        isaPkg::word   rs1Data;
        isaPkg::word   rs2Data;
        isaPkg::word   imm;
    } idExReg;

    typedef struct packed {
        logic          valid;
        isaPkg::word   pc;
        ctrlBundle     ctrl;
        isaPkg::regIdx rd;
        isaPkg::word   aluRes;
        isaPkg::word   storeData;
    } exMemReg;

    typedef struct packed {
        logic          valid;
        isaPkg::word   pc;
        logic          regWe;
        isaPkg::regIdx rd;
        isaPkg::word   wbData;
    } memWbReg;

    // one retired instruction
    typedef struct packed {
        isaPkg::word   pc;
        logic          regWe;
        isaPkg::regIdx rd;
        isaPkg::word   rdData;
    } commitInfo;

endpackage
